// File: source/hqc_pkg.sv
`default_nettype none

package hqc_pkg;

    // polynomial ring GF(2)[x]/(x^N - 1)
    localparam int N = 97;
    localparam int WEIGHT = 6;
    localparam int LOC_W = 7;
    localparam int IDX_W = 3;

    // repetition code, 8 bits x 12 copies, bit 96 stays zero
    localparam int MSG_W = 8;
    localparam int REP = 12;

    // bus words per dense vector
    localparam int WORD_W = 32;
    localparam int POLY_WORDS = 4;

    typedef logic [N-1:0] poly_t;
    typedef logic [LOC_W-1:0] loc_t;

    // word addresses on the wishbone port
    localparam logic [5:0] ADDR_CTRL = 6'd0;
    localparam logic [5:0] ADDR_H = 6'd1;
    localparam logic [5:0] ADDR_S = 6'd5;
    localparam logic [5:0] ADDR_R1 = 6'd9;
    localparam logic [5:0] ADDR_R2 = 6'd15;
    localparam logic [5:0] ADDR_E = 6'd21;
    localparam logic [5:0] ADDR_MSG = 6'd27;
    localparam logic [5:0] ADDR_U = 6'd28;
    localparam logic [5:0] ADDR_V = 6'd32;

    // tag carried by a product through the pipeline
    typedef enum logic {
        JOB_U,
        JOB_V
    } job_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE_U,
        SEQ_ISSUE_V,
        SEQ_WAIT
    } seq_state_t;

endpackage

`default_nettype wire

// File: source/encrypt_regs.sv
`timescale 1ns/1ps
`default_nettype none

module encrypt_regs (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      wb_cyc,
    input  wire logic                      wb_stb,
    input  wire logic                      wb_we,
    input  wire logic [5:0]                wb_adr,
    input  wire logic [31:0]               wb_dat_i,
    output logic [31:0]                    wb_dat_o,
    output logic                           wb_ack,
    output logic                           job_valid,
    input  wire logic                      job_ready,
    output hqc_pkg::job_t                  job_tag,
    output hqc_pkg::poly_t                 job_dense,
    input  wire logic [hqc_pkg::IDX_W-1:0] mult_idx,
    output hqc_pkg::loc_t                  mult_loc,
    input  wire logic [hqc_pkg::IDX_W-1:0] add_idx,
    input  wire logic                      add_sel_e,
    output hqc_pkg::loc_t                  add_loc,
    output logic [hqc_pkg::MSG_W-1:0]      msg,
    input  wire logic                      res_valid,
    input  wire hqc_pkg::job_t             res_tag,
    input  wire hqc_pkg::poly_t            res
);
    import hqc_pkg::*;

    localparam int PAD_W = POLY_WORDS * WORD_W;

    poly_t h_reg;
    poly_t s_reg;
    poly_t u_reg;
    poly_t v_reg;
    loc_t r1_loc [WEIGHT];
    loc_t r2_loc [WEIGHT];
    loc_t e_loc [WEIGHT];
    logic [MSG_W-1:0] msg_reg;
    seq_state_t state;
    logic busy;
    logic done;
    logic access;
    logic wr;
    logic op_wr;
    logic start_req;
    logic [31:0] rd_data;
    logic [5:0] off_h;
    logic [5:0] off_s;
    logic [5:0] off_r1;
    logic [5:0] off_r2;
    logic [5:0] off_e;
    logic [5:0] off_u;
    logic [5:0] off_v;
    logic in_h;
    logic in_s;
    logic in_r1;
    logic in_r2;
    logic in_e;
    logic in_u;
    logic in_v;

    // word k of a dense vector with the upper word zero padded
    function automatic logic [31:0] poly_word(poly_t p, logic [1:0] k);
        logic [PAD_W-1:0] pad;
        pad = PAD_W'(p);
        return pad[k*WORD_W +: WORD_W];
    endfunction

    function automatic poly_t poly_set(poly_t p, logic [1:0] k, logic [31:0] d);
        logic [PAD_W-1:0] pad;
        pad = PAD_W'(p);
        pad[k*WORD_W +: WORD_W] = d;
        return pad[N-1:0];
    endfunction

    assign access = wb_cyc && wb_stb && !wb_ack;
    assign wr = access && wb_we;
    // operands are frozen while a job runs
    assign op_wr = wr && !busy;
    assign start_req = op_wr && (wb_adr == ADDR_CTRL) && wb_dat_i[0];

    assign off_h = wb_adr - ADDR_H;
    assign off_s = wb_adr - ADDR_S;
    assign off_r1 = wb_adr - ADDR_R1;
    assign off_r2 = wb_adr - ADDR_R2;
    assign off_e = wb_adr - ADDR_E;
    assign off_u = wb_adr - ADDR_U;
    assign off_v = wb_adr - ADDR_V;

    assign in_h = (wb_adr >= ADDR_H) && (wb_adr < ADDR_S);
    assign in_s = (wb_adr >= ADDR_S) && (wb_adr < ADDR_R1);
    assign in_r1 = (wb_adr >= ADDR_R1) && (wb_adr < ADDR_R2);
    assign in_r2 = (wb_adr >= ADDR_R2) && (wb_adr < ADDR_E);
    assign in_e = (wb_adr >= ADDR_E) && (wb_adr < ADDR_MSG);
    assign in_u = (wb_adr >= ADDR_U) && (wb_adr < ADDR_V);
    assign in_v = (wb_adr >= ADDR_V) && (wb_adr < ADDR_V + 6'(POLY_WORDS));

    always_comb begin
        rd_data = '0;
        if (wb_adr == ADDR_CTRL) rd_data = {30'b0, done, busy};
        else if (in_h) rd_data = poly_word(h_reg, off_h[1:0]);
        else if (in_s) rd_data = poly_word(s_reg, off_s[1:0]);
        else if (in_r1) rd_data = 32'(r1_loc[off_r1[IDX_W-1:0]]);
        else if (in_r2) rd_data = 32'(r2_loc[off_r2[IDX_W-1:0]]);
        else if (in_e) rd_data = 32'(e_loc[off_e[IDX_W-1:0]]);
        else if (wb_adr == ADDR_MSG) rd_data = 32'(msg_reg);
        else if (in_u) rd_data = poly_word(u_reg, off_u[1:0]);
        else if (in_v) rd_data = poly_word(v_reg, off_v[1:0]);
    end

    always_ff @(posedge clk) begin
        if (rst) wb_ack <= 1'b0;
        else wb_ack <= access;
    end

    always_ff @(posedge clk) begin
        if (access) wb_dat_o <= rd_data;
    end

    // operand and message registers
    always_ff @(posedge clk) begin
        if (rst) begin
            h_reg <= '0;
            s_reg <= '0;
            msg_reg <= '0;
            for (int i = 0; i < WEIGHT; i++) begin
                r1_loc[i] <= '0;
                r2_loc[i] <= '0;
                e_loc[i] <= '0;
            end
        end else if (op_wr) begin
            if (in_h) h_reg <= poly_set(h_reg, off_h[1:0], wb_dat_i);
            if (in_s) s_reg <= poly_set(s_reg, off_s[1:0], wb_dat_i);
            if (in_r1) r1_loc[off_r1[IDX_W-1:0]] <= wb_dat_i[LOC_W-1:0];
            if (in_r2) r2_loc[off_r2[IDX_W-1:0]] <= wb_dat_i[LOC_W-1:0];
            if (in_e) e_loc[off_e[IDX_W-1:0]] <= wb_dat_i[LOC_W-1:0];
            if (wb_adr == ADDR_MSG) msg_reg <= wb_dat_i[MSG_W-1:0];
        end
    end

    // result capture by tag
    always_ff @(posedge clk) begin
        if (rst) begin
            u_reg <= '0;
            v_reg <= '0;
        end else if (res_valid) begin
            if (res_tag == JOB_U) u_reg <= res;
            else v_reg <= res;
        end
    end

    // job sequencer issues the u job then the v job back to back
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
            done <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start_req) begin
                        state <= SEQ_ISSUE_U;
                        done <= 1'b0;
                    end
                end
                SEQ_ISSUE_U: if (job_ready) state <= SEQ_ISSUE_V;
                SEQ_ISSUE_V: if (job_ready) state <= SEQ_WAIT;
                SEQ_WAIT: begin
                    // v is the last result out of the pipeline
                    if (res_valid && res_tag == JOB_V) begin
                        state <= SEQ_IDLE;
                        done <= 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign busy = (state != SEQ_IDLE);
    assign job_valid = (state == SEQ_ISSUE_U) || (state == SEQ_ISSUE_V);
    assign job_tag = (state == SEQ_ISSUE_V) ? JOB_V : JOB_U;
    assign job_dense = (state == SEQ_ISSUE_V) ? s_reg : h_reg;

    assign mult_loc = r2_loc[mult_idx];
    assign add_loc = add_sel_e ? e_loc[add_idx] : r1_loc[add_idx];
    assign msg = msg_reg;

    // both products leave the pipeline only after the v job was issued
    result_while_waiting: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> (state == SEQ_WAIT))
        else $error("result arrived while the sequencer was not waiting");

endmodule

`default_nettype wire

// File: source/sparse_mult.sv
`timescale 1ns/1ps
`default_nettype none

module sparse_mult (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      job_valid,
    output logic                           job_ready,
    input  wire hqc_pkg::job_t             job_tag,
    input  wire hqc_pkg::poly_t            job_dense,
    output logic [hqc_pkg::IDX_W-1:0]      mult_idx,
    input  wire hqc_pkg::loc_t             mult_loc,
    output logic                           prod_valid,
    input  wire logic                      prod_ready,
    output hqc_pkg::job_t                  prod_tag,
    output hqc_pkg::poly_t                 prod
);
    import hqc_pkg::*;

    poly_t dense;
    poly_t acc;
    poly_t rot;
    job_t tag;
    logic busy;
    logic [IDX_W-1:0] cnt;

    // cyclic left rotation by the current location
    assign rot = (dense << mult_loc) | (dense >> (N - int'(mult_loc)));

    // a new job may load in the same cycle the old product leaves
    assign job_ready = !busy && (!prod_valid || prod_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            prod_valid <= 1'b0;
            cnt <= '0;
        end else begin
            if (prod_valid && prod_ready) prod_valid <= 1'b0;
            if (job_valid && job_ready) begin
                busy <= 1'b1;
                cnt <= '0;
            end else if (busy) begin
                if (cnt == IDX_W'(WEIGHT)) begin
                    busy <= 1'b0;
                    prod_valid <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (job_valid && job_ready) begin
            dense <= job_dense;
            tag <= job_tag;
            acc <= '0;
        end else if (busy && cnt != IDX_W'(WEIGHT)) begin
            acc <= acc ^ rot;
        end
    end

    assign mult_idx = cnt;
    assign prod = acc;
    assign prod_tag = tag;

    loc_in_range: assert property (@(posedge clk) disable iff (rst)
        (busy && cnt != IDX_W'(WEIGHT)) |-> (int'(mult_loc) < N))
        else $error("r2 location out of range");

endmodule

`default_nettype wire

// File: source/sparse_add.sv
`timescale 1ns/1ps
`default_nettype none

module sparse_add (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      prod_valid,
    output logic                           prod_ready,
    input  wire hqc_pkg::job_t             prod_tag,
    input  wire hqc_pkg::poly_t            prod,
    output logic [hqc_pkg::IDX_W-1:0]      add_idx,
    output logic                           add_sel_e,
    input  wire hqc_pkg::loc_t             add_loc,
    output logic                           sum_valid,
    output hqc_pkg::job_t                  sum_tag,
    output hqc_pkg::poly_t                 sum
);
    import hqc_pkg::*;

    poly_t acc;
    job_t tag;
    logic busy;
    logic [IDX_W-1:0] cnt;

    assign prod_ready = !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            sum_valid <= 1'b0;
            cnt <= '0;
        end else begin
            sum_valid <= 1'b0;
            if (prod_valid && prod_ready) begin
                busy <= 1'b1;
                cnt <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                // last flip, single cycle pulse
                if (cnt == IDX_W'(WEIGHT - 1)) begin
                    busy <= 1'b0;
                    sum_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid && prod_ready) begin
            acc <= prod;
            tag <= prod_tag;
        end else if (busy) begin
            acc <= acc ^ (poly_t'(1) << add_loc);
        end
    end

    // u adds r1, v adds e
    assign add_sel_e = (tag == JOB_V);
    assign add_idx = cnt;
    assign sum = acc;
    assign sum_tag = tag;

    loc_in_range: assert property (@(posedge clk) disable iff (rst)
        busy |-> (int'(add_loc) < N))
        else $error("r1/e location out of range");

endmodule

`default_nettype wire

// File: source/codeword_add.sv
`timescale 1ns/1ps
`default_nettype none

module codeword_add (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic [hqc_pkg::MSG_W-1:0] msg,
    input  wire logic                      sum_valid,
    input  wire hqc_pkg::job_t             sum_tag,
    input  wire hqc_pkg::poly_t            sum,
    output logic                           res_valid,
    output hqc_pkg::job_t                  res_tag,
    output hqc_pkg::poly_t                 res
);
    import hqc_pkg::*;

    poly_t codeword;

    // each message bit fills REP consecutive positions
    always_comb begin
        codeword = '0;
        for (int i = 0; i < MSG_W * REP; i++) begin
            codeword[i] = msg[i / REP];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) res_valid <= 1'b0;
        else res_valid <= sum_valid;
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            res_tag <= sum_tag;
            res <= (sum_tag == JOB_V) ? (sum ^ codeword) : sum;
        end
    end

endmodule

`default_nettype wire

// File: source/hqc_encrypt.sv
`timescale 1ns/1ps
`default_nettype none

module hqc_encrypt (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        wb_cyc,
    input  wire logic        wb_stb,
    input  wire logic        wb_we,
    input  wire logic [5:0]  wb_adr,
    input  wire logic [31:0] wb_dat_i,
    output logic [31:0]      wb_dat_o,
    output logic             wb_ack
);
    import hqc_pkg::*;

    // job issue
    logic job_valid;
    logic job_ready;
    job_t job_tag;
    poly_t job_dense;
    logic [IDX_W-1:0] mult_idx;
    loc_t mult_loc;

    // multiply to add hand-off
    logic prod_valid;
    logic prod_ready;
    job_t prod_tag;
    poly_t prod;
    logic [IDX_W-1:0] add_idx;
    logic add_sel_e;
    loc_t add_loc;

    // add to codeword stage, then results
    logic sum_valid;
    job_t sum_tag;
    poly_t sum;
    logic [MSG_W-1:0] msg;
    logic res_valid;
    job_t res_tag;
    poly_t res;

    encrypt_regs regs (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .job_valid(job_valid), .job_ready(job_ready), .job_tag(job_tag),
        .job_dense(job_dense), .mult_idx(mult_idx), .mult_loc(mult_loc),
        .add_idx(add_idx), .add_sel_e(add_sel_e), .add_loc(add_loc),
        .msg(msg), .res_valid(res_valid), .res_tag(res_tag), .res(res)
    );

    sparse_mult mult (
        .clk(clk), .rst(rst),
        .job_valid(job_valid), .job_ready(job_ready), .job_tag(job_tag),
        .job_dense(job_dense), .mult_idx(mult_idx), .mult_loc(mult_loc),
        .prod_valid(prod_valid), .prod_ready(prod_ready), .prod_tag(prod_tag),
        .prod(prod)
    );

    sparse_add add (
        .clk(clk), .rst(rst),
        .prod_valid(prod_valid), .prod_ready(prod_ready), .prod_tag(prod_tag),
        .prod(prod), .add_idx(add_idx), .add_sel_e(add_sel_e), .add_loc(add_loc),
        .sum_valid(sum_valid), .sum_tag(sum_tag), .sum(sum)
    );

    codeword_add cw_add (
        .clk(clk), .rst(rst), .msg(msg),
        .sum_valid(sum_valid), .sum_tag(sum_tag), .sum(sum),
        .res_valid(res_valid), .res_tag(res_tag), .res(res)
    );

endmodule

`default_nettype wire

// File: verification/tb_hqc_model.svh
`ifndef TB_HQC_MODEL_SVH
`define TB_HQC_MODEL_SVH

`default_nettype none

typedef hqc_pkg::loc_t loc_list_t [hqc_pkg::WEIGHT];

// 32-bit LCG, full period constants
function automatic logic [31:0] lcg_step(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
endfunction

// multiply by x^k, wrapping at x^N = 1
function automatic hqc_pkg::poly_t rotate_left(input hqc_pkg::poly_t p, input int k);
    hqc_pkg::poly_t r;
    r = '0;
    for (int i = 0; i < hqc_pkg::N; i++) begin
        r[(i + k) % hqc_pkg::N] = p[i];
    end
    return r;
endfunction

// one rotation per location, a repeated location cancels
function automatic hqc_pkg::poly_t sparse_times_dense(input loc_list_t locs,
                                                      input hqc_pkg::poly_t d);
    hqc_pkg::poly_t r;
    r = '0;
    for (int j = 0; j < hqc_pkg::WEIGHT; j++) begin
        r = r ^ rotate_left(d, int'(locs[j]));
    end
    return r;
endfunction

function automatic hqc_pkg::poly_t flip_locations(input loc_list_t locs,
                                                  input hqc_pkg::poly_t p);
    hqc_pkg::poly_t r;
    r = p;
    for (int j = 0; j < hqc_pkg::WEIGHT; j++) begin
        r[locs[j]] = ~r[locs[j]];
    end
    return r;
endfunction

// 8 message bits, 12 copies each, top bit clear
function automatic hqc_pkg::poly_t repetition_encode(input logic [7:0] m);
    hqc_pkg::poly_t c;
    c = '0;
    for (int b = 0; b < 8; b++) begin
        for (int k = 0; k < 12; k++) begin
            c[b * 12 + k] = m[b];
        end
    end
    return c;
endfunction

function automatic hqc_pkg::poly_t words_to_poly(input logic [31:0] w0, input logic [31:0] w1,
                                                 input logic [31:0] w2, input logic [31:0] w3);
    logic [127:0] pack;
    pack = {w3, w2, w1, w0};
    return pack[hqc_pkg::N-1:0];
endfunction

function automatic logic [31:0] word_of_poly(input hqc_pkg::poly_t p, input int k);
    logic [127:0] pad;
    pad = {31'b0, p};
    return pad[k*32 +: 32];
endfunction

`default_nettype wire

`endif

// File: verification/tb_hqc_encrypt.sv
`timescale 1ns/1ps
`include "tb_hqc_model.svh"
`default_nettype none

module tb_hqc_encrypt;
    import hqc_pkg::*;

    localparam int RANDOM_JOBS = 40;
    localparam int JOB_CYCLES = 200;
    localparam int TIMEOUT_CYCLES = RANDOM_JOBS * JOB_CYCLES + 2000;
    localparam int ACK_WAIT = 4;
    localparam int POLL_LIMIT = 50;

    logic clk;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [5:0] wb_adr;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic wb_ack;

    int errors;
    int checks;
    int cycles = 0;
    logic [31:0] seed;
    logic [31:0] h_w [4];
    logic [31:0] s_w [4];
    loc_list_t r1;
    loc_list_t r2;
    loc_list_t e;
    logic [7:0] msg;
    poly_t exp_u;
    poly_t exp_v;

    hqc_encrypt UUT (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        seed = lcg_step(seed);
        return seed;
    endfunction

    function automatic loc_t random_loc();
        return loc_t'((next_random() >> 8) % 32'd97);
    endfunction

    task automatic expect_word(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // called 2 ns after a rising edge, returns at the same phase
    task automatic bus_access(input logic we, input logic [5:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waited;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_i = wdata;
        waited = 0;
        rdata = '0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!wb_ack && waited < ACK_WAIT);
        checks++;
        if (!wb_ack) begin
            errors++;
            $display("no acknowledge for the access to address %0d", adr);
        end else if (waited != 1) begin
            errors++;
            $display("[FAIL] %0d ns: ack after %0d cycles, expected 1", $time, waited);
        end
        rdata = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        @(posedge clk);
        #2;
        checks++;
        if (wb_ack) begin
            errors++;
            $display("[FAIL] %0d ns: ack held longer than one cycle", $time);
        end
    endtask

    task automatic bus_write(input logic [5:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [5:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, 32'h0, data);
    endtask

    task automatic randomize_operands();
        for (int k = 0; k < 3; k++) begin
            h_w[k] = next_random();
            s_w[k] = next_random();
        end
        // bit 96 of h and s left clear
        h_w[3] = 32'h0;
        s_w[3] = 32'h0;
        for (int j = 0; j < WEIGHT; j++) begin
            r1[j] = random_loc();
            r2[j] = random_loc();
            e[j] = random_loc();
        end
        msg = 8'(next_random() >> 24);
    endtask

    task automatic load_operands();
        for (int k = 0; k < 4; k++) begin
            bus_write(ADDR_H + 6'(k), h_w[k]);
            bus_write(ADDR_S + 6'(k), s_w[k]);
        end
        for (int j = 0; j < WEIGHT; j++) begin
            bus_write(ADDR_R1 + 6'(j), 32'(r1[j]));
            bus_write(ADDR_R2 + 6'(j), 32'(r2[j]));
            bus_write(ADDR_E + 6'(j), 32'(e[j]));
        end
        bus_write(ADDR_MSG, 32'(msg));
    endtask

    // u = r1 + r2.h, v = mG + s.r2 + e
    task automatic compute_expected();
        poly_t h;
        poly_t s;
        h = words_to_poly(h_w[0], h_w[1], h_w[2], h_w[3]);
        s = words_to_poly(s_w[0], s_w[1], s_w[2], s_w[3]);
        exp_u = flip_locations(r1, sparse_times_dense(r2, h));
        exp_v = flip_locations(e, sparse_times_dense(r2, s)) ^ repetition_encode(msg);
    endtask

    task automatic check_results(input string label);
        logic [31:0] d;
        for (int k = 0; k < 4; k++) begin
            bus_read(ADDR_U + 6'(k), d);
            expect_word($sformatf("%s u[%0d]", label, k), d, word_of_poly(exp_u, k));
            bus_read(ADDR_V + 6'(k), d);
            expect_word($sformatf("%s v[%0d]", label, k), d, word_of_poly(exp_v, k));
        end
    endtask

    task automatic wait_done();
        logic [31:0] d;
        int polls;
        d = '0;
        polls = 0;
        while (d[1] == 1'b0 && polls < POLL_LIMIT) begin
            bus_read(ADDR_CTRL, d);
            polls++;
        end
        checks++;
        if (d[1] == 1'b0) begin
            errors++;
            $display("job did not finish after %0d status reads", polls);
        end else if (d[0]) begin
            errors++;
            $display("[FAIL] %0d ns: busy still set together with done", $time);
        end
    endtask

    task automatic check_readback();
        logic [31:0] w;
        logic [31:0] d;
        for (int k = 0; k < 4; k++) begin
            w = next_random();
            bus_write(ADDR_H + 6'(k), w);
            bus_read(ADDR_H + 6'(k), d);
            // only bit 96 lives in the top word
            expect_word($sformatf("h[%0d] readback", k), d, (k == 3) ? (w & 32'h1) : w);
            bus_write(ADDR_S + 6'(k), w);
            bus_read(ADDR_S + 6'(k), d);
            expect_word($sformatf("s[%0d] readback", k), d, (k == 3) ? (w & 32'h1) : w);
        end
        w = next_random();
        bus_write(ADDR_R2 + 6'd2, w);
        bus_read(ADDR_R2 + 6'd2, d);
        expect_word("r2[2] readback", d, w & 32'h7f);
        bus_write(ADDR_MSG, w);
        bus_read(ADDR_MSG, d);
        expect_word("msg readback", d, w & 32'hff);
        bus_write(6'd40, w);
        bus_read(6'd40, d);
        expect_word("unmapped 40", d, 32'h0);
        bus_read(6'd63, d);
        expect_word("unmapped 63", d, 32'h0);
    endtask

    task automatic check_busy_restart();
        logic [31:0] d;
        logic [31:0] h0;
        randomize_operands();
        load_operands();
        compute_expected();
        h0 = h_w[0];
        bus_write(ADDR_CTRL, 32'h1);
        bus_read(ADDR_CTRL, d);
        expect_word("ctrl after start", d, 32'h1);
        // both land while the job runs
        bus_write(ADDR_H, ~h0);
        bus_write(ADDR_CTRL, 32'h1);
        wait_done();
        check_results("busy writes");
        bus_read(ADDR_H, d);
        expect_word("h[0] after busy write", d, h0);
        bus_write(ADDR_CTRL, 32'h1);
        bus_read(ADDR_CTRL, d);
        expect_word("ctrl after restart", d, 32'h1);
        wait_done();
        check_results("restart");
    endtask

    initial begin
        logic [31:0] d;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_i = '0;
        rst = 1'b1;
        errors = 0;
        checks = 0;
        seed = 32'd27370;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        bus_read(ADDR_CTRL, d);
        expect_word("ctrl after reset", d, 32'h0);
        exp_u = '0;
        exp_v = '0;
        check_results("after reset");

        check_readback();

        for (int n = 0; n < RANDOM_JOBS; n++) begin
            randomize_operands();
            load_operands();
            bus_write(ADDR_CTRL, 32'h1);
            wait_done();
            compute_expected();
            check_results($sformatf("job %0d", n));
        end

        // pairs that cancel in multiply and add
        randomize_operands();
        r2[1] = r2[0];
        r1[3] = r1[2];
        e[5] = e[4];
        load_operands();
        bus_write(ADDR_CTRL, 32'h1);
        wait_done();
        compute_expected();
        check_results("repeated locations");

        check_busy_restart();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+verification
source/hqc_pkg.sv
source/encrypt_regs.sv
source/sparse_mult.sv
source/sparse_add.sv
source/codeword_add.sv
source/hqc_encrypt.sv
verification/tb_hqc_encrypt.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_hqc_encrypt \
		-Mdir obj_dir -f all.f
	@out="$$(./obj_dir/Vtb_hqc_encrypt)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
